// File: source/simf_isa_pkg.sv
`default_nettype none

package simf_isa_pkg;

   // Control word fields
   localparam int FMT_MSB = 31;
   localparam int FMT_LSB = 24;
   localparam int OP_MSB  = 11;

   typedef enum logic [7:0] {
      FMT_VOP1  = 8'h01,
      FMT_VOP2  = 8'h02,
      FMT_VOPC  = 8'h04,
      FMT_VOP3A = 8'h08
   } fmt_e;

   // Non-compare opcodes kept in this lane
   typedef enum logic [11:0] {
      OP_CVT_U32 = 12'h006,  // V_CVT_F32_U32, VOP1
      OP_CVT_I32 = 12'h007,  // V_CVT_F32_I32, VOP1
      OP_MAX     = 12'h010   // V_MAX_F32, VOP2
   } opcode_e;

   // Compare predicate equals low opcode nibble
   typedef enum logic [3:0] {
      CMP_F   = 4'h0,
      CMP_LT  = 4'h1,
      CMP_EQ  = 4'h2,
      CMP_LE  = 4'h3,
      CMP_GT  = 4'h4,
      CMP_LG  = 4'h5,
      CMP_GE  = 4'h6,
      CMP_NGE = 4'h9,
      CMP_NLG = 4'hA,
      CMP_NGT = 4'hB,
      CMP_NLE = 4'hC,
      CMP_NEQ = 4'hD,
      CMP_NLT = 4'hE,
      CMP_TRU = 4'hF
   } cmp_pred_e;

endpackage

`default_nettype wire

// File: source/simf_lane_pkg.sv
`default_nettype none

package simf_lane_pkg;

   localparam int DATA_W   = 32;
   localparam int EXP_BIAS = 127;  // Single precision bias
   localparam int MANT_W   = 23;
   localparam int CNT_W    = 5;    // Leading zero count, up to 31

   // Result source for one instruction
   typedef enum logic [1:0] {
      CLS_PASS = 2'd0,  // EXEC off or unknown opcode
      CLS_CMP  = 2'd1,
      CLS_MAX  = 2'd2,
      CLS_CVT  = 2'd3
   } op_class_e;

   typedef enum logic {
      ST_IDLE    = 1'b0,
      ST_CONVERT = 1'b1
   } ctrl_state_e;

endpackage

`default_nettype wire

// File: source/simf_alu_decode.sv
`default_nettype none

module simf_alu_decode
  (
   input  wire [simf_isa_pkg::FMT_MSB:0] control_i,
   input  wire                           exec_i,
   output simf_lane_pkg::op_class_e      op_class_o,
   output simf_isa_pkg::cmp_pred_e       cmp_pred_o,
   output logic                          cvt_signed_o
   );

   logic [7:0]                      fmt;
   logic [simf_isa_pkg::OP_MSB:0]   opcode;
   logic                            is_cmp_op;
   logic                            is_cvt_op;

   assign fmt    = control_i[simf_isa_pkg::FMT_MSB:simf_isa_pkg::FMT_LSB];
   assign opcode = control_i[simf_isa_pkg::OP_MSB:0];

   // Compares live below 010h, codes 7 and 8 are holes
   assign is_cmp_op = (opcode[simf_isa_pkg::OP_MSB:4] == '0) &&
                      (opcode[3:0] != 4'h7) && (opcode[3:0] != 4'h8);

   assign is_cvt_op = (opcode == simf_isa_pkg::OP_CVT_U32) ||
                      (opcode == simf_isa_pkg::OP_CVT_I32);

   assign cvt_signed_o = (opcode == simf_isa_pkg::OP_CVT_I32);
   assign cmp_pred_o   = simf_isa_pkg::cmp_pred_e'(opcode[3:0]);

   always_comb
   begin
      op_class_o = simf_lane_pkg::CLS_PASS;  // Default path
      if (exec_i)
      begin
         case (fmt)
            simf_isa_pkg::FMT_VOPC,
            simf_isa_pkg::FMT_VOP3A:
            begin
               if (is_cmp_op)
                  op_class_o = simf_lane_pkg::CLS_CMP;
            end
            simf_isa_pkg::FMT_VOP2:
            begin
               if (opcode == simf_isa_pkg::OP_MAX)
                  op_class_o = simf_lane_pkg::CLS_MAX;
            end
            simf_isa_pkg::FMT_VOP1:
            begin
               if (is_cvt_op)
                  op_class_o = simf_lane_pkg::CLS_CVT;
            end
            default:
            begin
               op_class_o = simf_lane_pkg::CLS_PASS;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/simf_cmp_unit.sv
`default_nettype none

module simf_cmp_unit
  (
   input  wire [simf_lane_pkg::DATA_W-1:0] src1_i,
   input  wire [simf_lane_pkg::DATA_W-1:0] src2_i,
   input  simf_isa_pkg::cmp_pred_e         cmp_pred_i,
   output logic                            cmp_result_o,
   output logic [simf_lane_pkg::DATA_W-1:0] max_data_o
   );

   logic lt;
   logic eq;

   // Raw bit patterns compared as unsigned
   assign lt = (src1_i < src2_i);
   assign eq = (src1_i == src2_i);

   always_comb
   begin
      case (cmp_pred_i)
         simf_isa_pkg::CMP_F:   cmp_result_o = 1'b0;
         simf_isa_pkg::CMP_LT:  cmp_result_o = lt;
         simf_isa_pkg::CMP_EQ:  cmp_result_o = eq;
         simf_isa_pkg::CMP_LE:  cmp_result_o = lt | eq;
         simf_isa_pkg::CMP_GT:  cmp_result_o = ~(lt | eq);
         simf_isa_pkg::CMP_LG:  cmp_result_o = ~eq;      // Not equal
         simf_isa_pkg::CMP_GE:  cmp_result_o = ~lt;
         simf_isa_pkg::CMP_NGE: cmp_result_o = lt;
         simf_isa_pkg::CMP_NLG: cmp_result_o = eq;       // Equal
         simf_isa_pkg::CMP_NGT: cmp_result_o = lt | eq;
         simf_isa_pkg::CMP_NLE: cmp_result_o = ~(lt | eq);
         simf_isa_pkg::CMP_NEQ: cmp_result_o = ~eq;
         simf_isa_pkg::CMP_NLT: cmp_result_o = ~lt;
         simf_isa_pkg::CMP_TRU: cmp_result_o = 1'b1;
         default:               cmp_result_o = 1'b0;     // Codes 7 and 8
      endcase
   end

   // Source 1 wins ties
   assign max_data_o = lt ? src2_i : src1_i;

endmodule

`default_nettype wire

// File: source/simf_int_to_float.sv
`default_nettype none

module simf_int_to_float
  (
   input  wire                             clk,
   input  wire                             arst_n_i,
   input  wire                             start_i,
   input  wire                             signed_i,
   input  wire [simf_lane_pkg::DATA_W-1:0] src_i,
   output logic                            done_o,
   output logic [simf_lane_pkg::DATA_W-1:0] data_o
   );

   typedef enum logic [1:0] {
      CV_IDLE  = 2'd0,
      CV_SHIFT = 2'd1,
      CV_PACK  = 2'd2
   } cv_state_e;

   cv_state_e                          state;
   logic                               sign_q;
   logic [simf_lane_pkg::DATA_W-1:0]   mag_q;
   logic [simf_lane_pkg::CNT_W-1:0]    cnt_q;
   logic                               neg_in;
   logic [simf_lane_pkg::DATA_W-1:0]   mag_in;
   logic [simf_lane_pkg::DATA_W-simf_lane_pkg::MANT_W-2:0] exp_val;

   assign neg_in = signed_i & src_i[simf_lane_pkg::DATA_W-1];
   assign mag_in = neg_in ? (~src_i + 1'b1) : src_i;  // 80000000h stays as 2^31

   // Leading one sits at bit 31 - cnt
   assign exp_val = 8'(simf_lane_pkg::EXP_BIAS + simf_lane_pkg::DATA_W - 1) - {3'b000, cnt_q};

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state  <= CV_IDLE;
         done_o <= 1'b0;
      end
      else
      begin
         done_o <= 1'b0;
         case (state)
            CV_IDLE:
            begin
               if (start_i)
               begin
                  if (mag_in == '0)
                     done_o <= 1'b1;  // Zero needs no normalizing
                  else if (mag_in[simf_lane_pkg::DATA_W-1])
                     state <= CV_PACK;
                  else
                     state <= CV_SHIFT;
               end
            end
            CV_SHIFT:
            begin
               if (mag_q[simf_lane_pkg::DATA_W-2])
                  state <= CV_PACK;  // Top bit set after this shift
            end
            CV_PACK:
            begin
               state  <= CV_IDLE;
               done_o <= 1'b1;
            end
            default:
            begin
               state <= CV_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      case (state)
         CV_IDLE:
         begin
            if (start_i)
            begin
               sign_q <= neg_in;
               mag_q  <= mag_in;
               cnt_q  <= '0;
               data_o <= '0;
            end
         end
         CV_SHIFT:
         begin
            mag_q <= mag_q << 1;
            cnt_q <= cnt_q + 1'b1;
         end
         CV_PACK:
         begin
            // Bits below the mantissa are dropped
            data_o <= {sign_q, exp_val,
                       mag_q[simf_lane_pkg::DATA_W-2 -: simf_lane_pkg::MANT_W]};
         end
         default:
         begin
            data_o <= data_o;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: source/simf_lane_ctrl.sv
`default_nettype none

module simf_lane_ctrl
  (
   input  wire                              clk,
   input  wire                              arst_n_i,
   input  wire                              start_i,
   input  simf_lane_pkg::op_class_e         op_class_i,
   input  wire                              vcc_i,
   input  wire                              cmp_result_i,
   input  wire [simf_lane_pkg::DATA_W-1:0]  max_data_i,
   input  wire                              cvt_done_i,
   input  wire [simf_lane_pkg::DATA_W-1:0]  cvt_data_i,
   output logic                             cvt_start_o,
   output logic                             busy_o,
   output logic                             done_o,
   output logic [simf_lane_pkg::DATA_W-1:0] vgpr_dest_data_o,
   output logic                             dest_vcc_o
   );

   simf_lane_pkg::ctrl_state_e state;
   logic                       vcc_q;  // VCC seen at start

   assign busy_o      = (state == simf_lane_pkg::ST_CONVERT);
   assign cvt_start_o = start_i && (state == simf_lane_pkg::ST_IDLE) &&
                        (op_class_i == simf_lane_pkg::CLS_CVT);

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state            <= simf_lane_pkg::ST_IDLE;
         done_o           <= 1'b0;
         vgpr_dest_data_o <= '0;
         dest_vcc_o       <= 1'b0;
         vcc_q            <= 1'b0;
      end
      else
      begin
         done_o <= 1'b0;
         case (state)
            simf_lane_pkg::ST_IDLE:
            begin
               if (start_i)
               begin
                  vcc_q <= vcc_i;
                  case (op_class_i)
                     simf_lane_pkg::CLS_CMP:
                     begin
                        vgpr_dest_data_o <= '0;
                        dest_vcc_o       <= cmp_result_i;
                        done_o           <= 1'b1;
                     end
                     simf_lane_pkg::CLS_MAX:
                     begin
                        vgpr_dest_data_o <= max_data_i;
                        dest_vcc_o       <= vcc_i;
                        done_o           <= 1'b1;
                     end
                     simf_lane_pkg::CLS_CVT:
                     begin
                        state <= simf_lane_pkg::ST_CONVERT;  // Wait for normalizer
                     end
                     default:
                     begin
                        vgpr_dest_data_o <= '0;  // Pass vcc through
                        dest_vcc_o       <= vcc_i;
                        done_o           <= 1'b1;
                     end
                  endcase
               end
            end
            simf_lane_pkg::ST_CONVERT:
            begin
               if (cvt_done_i)
               begin
                  vgpr_dest_data_o <= cvt_data_i;
                  dest_vcc_o       <= vcc_q;
                  done_o           <= 1'b1;
                  state            <= simf_lane_pkg::ST_IDLE;
               end
            end
            default:
            begin
               state <= simf_lane_pkg::ST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/simf_alu.sv
`default_nettype none

module simf_alu
  (
   input  wire                              clk,
   input  wire                              arst_n_i,
   input  wire                              start_i,
   input  wire [simf_isa_pkg::FMT_MSB:0]    control_i,
   input  wire                              exec_i,
   input  wire                              vcc_i,
   input  wire [simf_lane_pkg::DATA_W-1:0]  src1_i,
   input  wire [simf_lane_pkg::DATA_W-1:0]  src2_i,
   output logic                             busy_o,
   output logic                             done_o,
   output logic [simf_lane_pkg::DATA_W-1:0] vgpr_dest_data_o,
   output logic                             dest_vcc_o
   );

   simf_lane_pkg::op_class_e         op_class;
   simf_isa_pkg::cmp_pred_e          cmp_pred;
   logic                             cvt_signed;
   logic                             cmp_result;
   logic [simf_lane_pkg::DATA_W-1:0] max_data;
   logic                             cvt_start;
   logic                             cvt_done;
   logic [simf_lane_pkg::DATA_W-1:0] cvt_data;

   simf_alu_decode decode_inst (
      .control_i    (control_i),
      .exec_i       (exec_i),
      .op_class_o   (op_class),
      .cmp_pred_o   (cmp_pred),
      .cvt_signed_o (cvt_signed)
   );

   simf_cmp_unit cmp_inst (
      .src1_i       (src1_i),
      .src2_i       (src2_i),
      .cmp_pred_i   (cmp_pred),
      .cmp_result_o (cmp_result),
      .max_data_o   (max_data)
   );

   // Replaces the external FPU for the two conversions
   simf_int_to_float cvt_inst (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .start_i  (cvt_start),
      .signed_i (cvt_signed),
      .src_i    (src1_i),
      .done_o   (cvt_done),
      .data_o   (cvt_data)
   );

   simf_lane_ctrl ctrl_inst (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .start_i          (start_i),
      .op_class_i       (op_class),
      .vcc_i            (vcc_i),
      .cmp_result_i     (cmp_result),
      .max_data_i       (max_data),
      .cvt_done_i       (cvt_done),
      .cvt_data_i       (cvt_data),
      .cvt_start_o      (cvt_start),
      .busy_o           (busy_o),
      .done_o           (done_o),
      .vgpr_dest_data_o (vgpr_dest_data_o),
      .dest_vcc_o       (dest_vcc_o)
   );

endmodule

`default_nettype wire

// File: sim/simf_alu_checker.sv
`default_nettype none

module simf_alu_checker
  (
   input wire clk,
   input wire arst_n_i,
   input wire start_i,
   input wire busy_o,
   input wire done_o
   );

   logic [5:0] busy_cnt;  // Consecutive busy cycles

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         busy_cnt <= '0;
      else if (busy_o)
         busy_cnt <= busy_cnt + 6'd1;
      else
         busy_cnt <= '0;
   end

   done_single: assert property (@(posedge clk) disable iff (!arst_n_i)
      done_o |=> !done_o)
      else $error("done_o stayed high for two cycles");

   // A done needs an accepted start or a running conversion
   done_cause: assert property (@(posedge clk) disable iff (!arst_n_i)
      $rose(done_o) |-> ($past(start_i && !busy_o) || $past(busy_o)))
      else $error("done_o rose without an accepted start");

   busy_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
      busy_cnt <= 6'd36)
      else $error("busy_o stayed high longer than 36 cycles");

   reset_done: assert property (@(posedge clk) !arst_n_i |-> !done_o)
      else $error("done_o high during reset");

endmodule

bind simf_alu simf_alu_checker checker_inst (
   .clk      (clk),
   .arst_n_i (arst_n_i),
   .start_i  (start_i),
   .busy_o   (busy_o),
   .done_o   (done_o)
);

`default_nettype wire

// File: sim/simf_alu_tb.sv
`default_nettype none

module simf_alu_tb;

   logic        clk;
   logic        arst_n_i;
   logic        start_i;
   logic [31:0] control_i;
   logic        exec_i;
   logic        vcc_i;
   logic [31:0] src1_i;
   logic [31:0] src2_i;
   wire         busy_o;
   wire         done_o;
   wire  [31:0] vgpr_dest_data_o;
   wire         dest_vcc_o;

   int          errors;
   int          checks;
   logic [31:0] rng_state;

   simf_alu simf_alu_inst (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .start_i          (start_i),
      .control_i        (control_i),
      .exec_i           (exec_i),
      .vcc_i            (vcc_i),
      .src1_i           (src1_i),
      .src2_i           (src2_i),
      .busy_o           (busy_o),
      .done_o           (done_o),
      .vgpr_dest_data_o (vgpr_dest_data_o),
      .dest_vcc_o       (dest_vcc_o)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic rand_word(output logic [31:0] w);
      rng_state = lcg_next(rng_state);
      w = rng_state;
   endtask

   function automatic logic [31:0] ctrl_word(input logic [7:0] fmt, input logic [11:0] op);
      return {fmt, 12'h000, op};
   endfunction

   // Unsigned ordering of raw bit patterns
   function automatic logic pred_model(input logic [3:0] p, input logic [31:0] a,
                                       input logic [31:0] b);
      case (p)
         4'h1:    return a < b;
         4'h2:    return a == b;
         4'h3:    return a <= b;
         4'h4:    return a > b;
         4'h5:    return a != b;
         4'h6:    return a >= b;
         4'h9:    return !(a >= b);
         4'hA:    return a == b;
         4'hB:    return !(a > b);
         4'hC:    return !(a <= b);
         4'hD:    return a != b;
         4'hE:    return !(a < b);
         4'hF:    return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic [31:0] cvt_model(input logic sgn_op, input logic [31:0] x);
      logic        sign;
      logic [31:0] mag;
      int          lead;
      sign = sgn_op & x[31];
      mag  = sign ? (32'd0 - x) : x;
      if (mag == 32'd0)
         return 32'd0;
      lead = 31;
      while (!mag[lead])
         lead--;
      mag = mag << (31 - lead);  // Leading one to bit 31
      return {sign, 8'(127 + lead), mag[30:8]};
   endfunction

   // Load, one shift per leading zero, pack, then result register
   function automatic int cvt_cycles(input logic sgn_op, input logic [31:0] x);
      logic [31:0] mag;
      int          lz;
      mag = (sgn_op && x[31]) ? (32'd0 - x) : x;
      if (mag == 32'd0)
         return 2;
      lz = 0;
      while (!mag[31 - lz])
         lz++;
      return lz + 3;
   endfunction

   task automatic issue(input logic [31:0] ctrl, input logic ex, input logic vcc,
                        input logic [31:0] a, input logic [31:0] b, output int cycles);
      @(posedge clk);
      control_i <= ctrl;
      exec_i    <= ex;
      vcc_i     <= vcc;
      src1_i    <= a;
      src2_i    <= b;
      start_i   <= 1'b1;
      @(posedge clk);
      start_i <= 1'b0;
      cycles = 1;
      @(negedge clk);
      while (!done_o && cycles < 64)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!done_o)
      begin
         $display("Timeout: done_o did not arrive within 64 cycles, time %0t", $time);
         errors++;
         cycles = -1;
      end
   endtask

   task automatic run_check(input logic [31:0] ctrl, input logic ex, input logic vcc,
                            input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] exp_data, input logic exp_vcc,
                            input int exp_cycles);
      int cycles;
      issue(ctrl, ex, vcc, a, b, cycles);
      checks++;
      if (cycles >= 0)
      begin
         assert (vgpr_dest_data_o === exp_data)
         else
         begin
            $display("ERROR time=%0t vgpr_dest_data_o expected=%08h actual=%08h",
                     $time, exp_data, vgpr_dest_data_o);
            errors++;
         end
         assert (dest_vcc_o === exp_vcc)
         else
         begin
            $display("ERROR time=%0t dest_vcc_o expected=%0b actual=%0b",
                     $time, exp_vcc, dest_vcc_o);
            errors++;
         end
         assert (cycles == exp_cycles)
         else
         begin
            $display("ERROR time=%0t done_o latency expected=%0d actual=%0d",
                     $time, exp_cycles, cycles);
            errors++;
         end
      end
   endtask

   // Second start arrives while the normalizer is busy
   task automatic overlap_check();
      logic [31:0] x;
      int          n;
      int          dones;
      logic [31:0] got_data;
      logic        got_vcc;
      x        = 32'h0000_0123;
      dones    = 0;
      got_data = '0;
      got_vcc  = 1'b0;
      @(posedge clk);
      control_i <= ctrl_word(simf_isa_pkg::FMT_VOP1, simf_isa_pkg::OP_CVT_U32);
      exec_i    <= 1'b1;
      vcc_i     <= 1'b1;
      src1_i    <= x;
      start_i   <= 1'b1;
      @(posedge clk);
      start_i <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!busy_o && n < 64)
      begin
         @(negedge clk);
         n++;
      end
      if (!busy_o)
      begin
         $display("Timeout: busy_o never rose for the conversion, time %0t", $time);
         errors++;
      end
      @(posedge clk);
      control_i <= ctrl_word(simf_isa_pkg::FMT_VOPC, 12'h00F);
      src1_i    <= 32'hFFFF_FFFF;
      vcc_i     <= 1'b0;
      start_i   <= 1'b1;
      @(posedge clk);
      start_i <= 1'b0;
      for (n = 0; n < 64; n++)
      begin
         @(negedge clk);
         if (done_o)
         begin
            dones++;
            got_data = vgpr_dest_data_o;
            got_vcc  = dest_vcc_o;
         end
      end
      checks++;
      assert (dones == 1)
      else
      begin
         $display("ERROR time=%0t done_o pulses expected=1 actual=%0d", $time, dones);
         errors++;
      end
      assert (got_data === cvt_model(1'b0, x))
      else
      begin
         $display("ERROR time=%0t vgpr_dest_data_o expected=%08h actual=%08h",
                  $time, cvt_model(1'b0, x), got_data);
         errors++;
      end
      assert (got_vcc === 1'b1)
      else
      begin
         $display("ERROR time=%0t dest_vcc_o expected=1 actual=%0b", $time, got_vcc);
         errors++;
      end
   endtask

   initial
   begin
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [7:0]  fmt;
      logic        v;
      int          f;
      int          p;
      int          i;
      clk       = 1'b0;
      arst_n_i  = 1'b0;
      start_i   = 1'b0;
      control_i = '0;
      exec_i    = 1'b0;
      vcc_i     = 1'b0;
      src1_i    = '0;
      src2_i    = '0;
      errors    = 0;
      checks    = 0;
      rng_state = 32'd62;
      repeat (2) @(posedge clk);
      arst_n_i <= 1'b1;

      for (f = 0; f < 2; f++)
      begin
         fmt = (f == 0) ? simf_isa_pkg::FMT_VOPC : simf_isa_pkg::FMT_VOP3A;
         for (p = 0; p < 16; p++)
         begin
            if (p == 7 || p == 8)
               continue;  // Not compares
            for (i = 0; i < 4; i++)
            begin
               rand_word(a);
               rand_word(b);
               rand_word(c);
               v = c[20];
               case (i)
                  1: b = a;
                  2:
                  begin
                     a = 32'h0;
                     b = 32'h8000_0000;
                  end
                  3:
                  begin
                     a = 32'hFFFF_FFFF;
                     b = 32'h8000_0000;
                  end
                  default: ;
               endcase
               run_check(ctrl_word(fmt, 12'(p)), 1'b1, v, a, b, 32'd0,
                         pred_model(4'(p), a, b), 1);
            end
         end
      end

      for (i = 0; i < 10; i++)
      begin
         rand_word(a);
         rand_word(b);
         rand_word(c);
         v = c[20];
         if (i == 1)
            b = a;
         if (i == 2)
         begin
            a = 32'h0;
            b = 32'hFFFF_FFFF;
         end
         run_check(ctrl_word(simf_isa_pkg::FMT_VOP2, simf_isa_pkg::OP_MAX), 1'b1, v,
                   a, b, (a >= b) ? a : b, v, 1);
      end

      for (f = 0; f < 2; f++)
      begin
         for (i = 0; i < 12; i++)
         begin
            rand_word(a);
            rand_word(c);
            v = c[20];
            case (i)
               0: a = 32'h0;
               1: a = 32'h1;
               2: a = 32'hFFFF_FFFF;
               3: a = 32'h8000_0000;
               4: a = 32'hFFFF_FF9C;  // -100
               5: a = 32'd100;
               default: ;
            endcase
            run_check(ctrl_word(simf_isa_pkg::FMT_VOP1, (f == 0) ? simf_isa_pkg::OP_CVT_U32
                                                              : simf_isa_pkg::OP_CVT_I32),
                      1'b1, v, a, 32'h0, cvt_model(f[0], a), v, cvt_cycles(f[0], a));
         end
      end

      // EXEC off, then unknown encodings
      run_check(ctrl_word(simf_isa_pkg::FMT_VOPC, 12'h002), 1'b0, 1'b0,
                32'h5, 32'h5, 32'd0, 1'b0, 1);
      run_check(ctrl_word(simf_isa_pkg::FMT_VOP3A, 12'h00F), 1'b0, 1'b0,
                32'h1, 32'h2, 32'd0, 1'b0, 1);
      run_check(ctrl_word(simf_isa_pkg::FMT_VOP1, simf_isa_pkg::OP_CVT_I32), 1'b0, 1'b1,
                32'h8000_0000, 32'h0, 32'd0, 1'b1, 1);
      run_check(ctrl_word(simf_isa_pkg::FMT_VOP2, 12'h011), 1'b1, 1'b1,
                32'h7, 32'h3, 32'd0, 1'b1, 1);
      run_check(ctrl_word(8'h10, 12'h002), 1'b1, 1'b0, 32'h4, 32'h4, 32'd0, 1'b0, 1);
      run_check(ctrl_word(simf_isa_pkg::FMT_VOPC, 12'h007), 1'b1, 1'b1,
                32'h1, 32'h9, 32'd0, 1'b1, 1);
      run_check(ctrl_word(simf_isa_pkg::FMT_VOP1, 12'h010), 1'b1, 1'b0,
                32'h9, 32'h1, 32'd0, 1'b0, 1);

      overlap_check();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: simf_alu.f
source/simf_isa_pkg.sv
source/simf_lane_pkg.sv
source/simf_alu_decode.sv
source/simf_cmp_unit.sv
source/simf_int_to_float.sv
source/simf_lane_ctrl.sv
source/simf_alu.sv
sim/simf_alu_checker.sv
sim/simf_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then scan the log

verilator --binary --assert -Wno-fatal --top-module simf_alu_tb -f simf_alu.f \
   && ./obj_dir/Vsimf_alu_tb > sim.log 2>&1 \
   || { echo "Build or simulation run failed, see sim.log"; exit 1; }

grep -q "Verification failed" sim.log && { echo "Testbench reported errors"; exit 1; }
echo "Simulation finished, no errors in sim.log"
exit 0
